// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tb_ncpu_core
FILELIST = sim.f
BUILD    = obj_dir
LOG      = sim.log
PASS_MSG = Test completed successfully
SIM_ARGS = +verilator+error+limit+1000

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: build
	./$(BUILD)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(SIM) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD) $(LOG)

// File: alu_ex.sv
`include "ncpu_defs.svh"

module alu_ex
(
   input  logic                    clk,
   input  logic                    rst_n,
   exop_if.dst                     exop,
   output logic                    wb_valid,
   output logic [`NCPU_PRF_AW-1:0] wb_prd,
   output logic [`NCPU_DW-1:0]     wb_data,
   input  logic                    wb_ready,
   output logic                    wr_en,
   output logic [`NCPU_PRF_AW-1:0] wr_addr,
   output logic [`NCPU_DW-1:0]     wr_data
);
   import ncpu_pkg::*;

   localparam int SHW = $clog2(`NCPU_DW);

   logic [`NCPU_DW-1:0] result;
   logic [SHW-1:0]      shamt;
   logic                accept;

   assign shamt = exop.operand2[SHW-1:0];

   always_comb
   begin
      case (exop.op)
         ALU_ADD: result = exop.operand1 + exop.operand2;
         ALU_SUB: result = exop.operand1 - exop.operand2;
         ALU_AND: result = exop.operand1 & exop.operand2;
         ALU_OR:  result = exop.operand1 | exop.operand2;
         ALU_XOR: result = exop.operand1 ^ exop.operand2;
         ALU_SLL: result = exop.operand1 << shamt;
         ALU_SRL: result = exop.operand1 >> shamt;   // Logical
         ALU_LI:  result = exop.imm;
         default: result = '0;
      endcase
   end

   assign exop.ready = !wb_valid || wb_ready;
   assign accept     = exop.valid && exop.ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         wb_valid <= 1'b0;
      else if (accept)
         wb_valid <= 1'b1;
      else if (wb_ready)
         wb_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (accept)
      begin
         wb_prd  <= exop.prd;
         wb_data <= result;
      end
   end

   // Register file write only when the result actually leaves
   assign wr_en   = wb_valid && wb_ready;
   assign wr_addr = wb_prd;
   assign wr_data = wb_data;

endmodule

// File: issue.sv
`include "ncpu_defs.svh"

module issue
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    in_valid,
   input  ncpu_pkg::alu_op_t       in_op,
   input  logic [`NCPU_PRF_AW-1:0] in_prs1,
   input  logic [`NCPU_PRF_AW-1:0] in_prs2,
   input  logic [`NCPU_PRF_AW-1:0] in_prd,
   input  logic [`NCPU_DW-1:0]     in_imm,
   output logic                    in_ready,
   input  logic                    wr_en,
   input  logic [`NCPU_PRF_AW-1:0] wr_addr,
   insn_if.src                     insn
);
   import ncpu_pkg::*;

   logic                    q_valid;
   alu_op_t                 q_op;
   logic [`NCPU_PRF_AW-1:0] q_prs1;
   logic [`NCPU_PRF_AW-1:0] q_prs2;
   logic [`NCPU_PRF_AW-1:0] q_prd;
   logic [`NCPU_DW-1:0]     q_imm;
   logic [`NCPU_PRF_N-1:0]  busy;   // One bit per physical register
   logic                    rs1_ok;
   logic                    rs2_ok;
   logic                    rd_ok;
   logic                    load;
   logic                    take;

   // A register written back this cycle counts as ready
   assign rs1_ok = !busy[q_prs1] || (wr_en && wr_addr == q_prs1);
   assign rs2_ok = !busy[q_prs2] || (wr_en && wr_addr == q_prs2);
   // Destination must not still have an older write in flight
   assign rd_ok  = !busy[q_prd] || (wr_en && wr_addr == q_prd);

   assign insn.valid = q_valid && rd_ok && ((q_op == ALU_LI) || (rs1_ok && rs2_ok));
   assign insn.op    = q_op;
   assign insn.prs1  = q_prs1;
   assign insn.prs2  = q_prs2;
   assign insn.prd   = q_prd;
   assign insn.imm   = q_imm;

   assign take     = insn.valid && insn.ready;
   assign in_ready = !q_valid || take;
   assign load     = in_valid && in_ready;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         q_valid <= 1'b0;
      else if (load)
         q_valid <= 1'b1;
      else if (take)
         q_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (load)
      begin
         q_op   <= in_op;
         q_prs1 <= in_prs1;
         q_prs2 <= in_prs2;
         q_prd  <= in_prd;
         q_imm  <= in_imm;
      end
   end

   // Scoreboard
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         busy <= '0;
      else
      begin
         if (wr_en)
            busy[wr_addr] <= 1'b0;
         if (take)
            busy[q_prd] <= 1'b1;   // Set wins over same-cycle clear
      end
   end

endmodule

// File: ncpu_core.sv
`include "ncpu_defs.svh"

module ncpu_core
(
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    in_valid,
   input  ncpu_pkg::alu_op_t       in_op,
   input  logic [`NCPU_PRF_AW-1:0] in_prs1,
   input  logic [`NCPU_PRF_AW-1:0] in_prs2,
   input  logic [`NCPU_PRF_AW-1:0] in_prd,
   input  logic [`NCPU_DW-1:0]     in_imm,
   output logic                    in_ready,
   output logic                    wb_valid,
   output logic [`NCPU_PRF_AW-1:0] wb_prd,
   output logic [`NCPU_DW-1:0]     wb_data,
   input  logic                    wb_ready
);
   // Write-back port, shared by the register file and the scoreboard
   logic                    wr_en;
   logic [`NCPU_PRF_AW-1:0] wr_addr;
   logic [`NCPU_DW-1:0]     wr_data;

   insn_if   insn_bus ();
   prf_rd_if rd_bus ();
   exop_if   exop_bus ();

   issue issue_i
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .in_valid (in_valid),
      .in_op    (in_op),
      .in_prs1  (in_prs1),
      .in_prs2  (in_prs2),
      .in_prd   (in_prd),
      .in_imm   (in_imm),
      .in_ready (in_ready),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .insn     (insn_bus.src)
   );

   ro ro_i
   (
      .clk   (clk),
      .rst_n (rst_n),
      .insn  (insn_bus.dst),
      .rd    (rd_bus.req),
      .exop  (exop_bus.src)
   );

   prf prf_i
   (
      .clk     (clk),
      .rst_n   (rst_n),
      .rd      (rd_bus.mem),
      .wr_en   (wr_en),
      .wr_addr (wr_addr),
      .wr_data (wr_data)
   );

   alu_ex alu_ex_i
   (
      .clk      (clk),
      .rst_n    (rst_n),
      .exop     (exop_bus.dst),
      .wb_valid (wb_valid),
      .wb_prd   (wb_prd),
      .wb_data  (wb_data),
      .wb_ready (wb_ready),
      .wr_en    (wr_en),
      .wr_addr  (wr_addr),
      .wr_data  (wr_data)
   );

endmodule

// File: ncpu_core_assert.sv
`include "ncpu_defs.svh"

module ncpu_core_assert
(
   input logic                    clk,
   input logic                    rst_n,
   input logic                    in_ready,
   input logic                    wb_valid,
   input logic                    wb_ready,
   input logic [`NCPU_PRF_AW-1:0] wb_prd,
   input logic [`NCPU_DW-1:0]     wb_data
);
   timeunit 1ns;
   timeprecision 100ps;

   int n_fail = 0;

   // Stalled write-back keeps valid and payload
   wb_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
      wb_valid && !wb_ready |=> wb_valid && $stable(wb_prd) && $stable(wb_data))
   else
   begin
      $error("wb_valid dropped or payload changed while wb_ready was low");
      n_fail++;
   end

   in_ready_a: assert property (@(posedge clk) $rose(rst_n) |-> in_ready)
   else
   begin
      $error("in_ready low in the first cycle after reset");
      n_fail++;
   end

   wb_reset_a: assert property (@(posedge clk) !rst_n |=> !wb_valid)
   else
   begin
      $error("wb_valid high during reset");
      n_fail++;
   end

endmodule

bind ncpu_core ncpu_core_assert assert_i
(
   .clk      (clk),
   .rst_n    (rst_n),
   .in_ready (in_ready),
   .wb_valid (wb_valid),
   .wb_ready (wb_ready),
   .wb_prd   (wb_prd),
   .wb_data  (wb_data)
);

// File: ncpu_defs.svh
`ifndef NCPU_DEFS_SVH
`define NCPU_DEFS_SVH

// Datapath width
`define NCPU_DW 32

// Physical register file geometry
`define NCPU_PRF_AW 5
`define NCPU_PRF_N 32

`endif

// File: ncpu_ifs.sv
`include "ncpu_defs.svh"

// Issue to read-operand stage
interface insn_if;
   import ncpu_pkg::*;

   logic                    valid;
   logic                    ready;
   alu_op_t                 op;
   logic [`NCPU_PRF_AW-1:0] prs1;
   logic [`NCPU_PRF_AW-1:0] prs2;
   logic [`NCPU_PRF_AW-1:0] prd;
   logic [`NCPU_DW-1:0]     imm;

   modport src (output valid, op, prs1, prs2, prd, imm, input ready);
   modport dst (input valid, op, prs1, prs2, prd, imm, output ready);
endinterface

// Read-operand stage to execute
interface exop_if;
   import ncpu_pkg::*;

   logic                    valid;
   logic                    ready;
   alu_op_t                 op;
   logic [`NCPU_PRF_AW-1:0] prd;
   logic [`NCPU_DW-1:0]     imm;
   logic [`NCPU_DW-1:0]     operand1;
   logic [`NCPU_DW-1:0]     operand2;

   modport src (output valid, op, prd, imm, operand1, operand2, input ready);
   modport dst (input valid, op, prd, imm, operand1, operand2, output ready);
endinterface

// Register file read ports, data one cycle after re
interface prf_rd_if;
   logic                    re1;
   logic [`NCPU_PRF_AW-1:0] raddr1;
   logic                    re2;
   logic [`NCPU_PRF_AW-1:0] raddr2;
   logic [`NCPU_DW-1:0]     rdata1;
   logic [`NCPU_DW-1:0]     rdata2;

   modport req (output re1, raddr1, re2, raddr2, input rdata1, rdata2);
   modport mem (input re1, raddr1, re2, raddr2, output rdata1, rdata2);
endinterface

// File: ncpu_pkg.sv
package ncpu_pkg;

   // ALU opcodes, 3-bit encoding
   typedef enum logic [2:0]
   {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4,
      ALU_SLL = 3'd5,  // Shift amount from operand2[4:0]
      ALU_SRL = 3'd6,
      ALU_LI  = 3'd7   // Result is the immediate
   } alu_op_t;

endpackage

// File: prf.sv
`include "ncpu_defs.svh"

module prf
(
   input  logic                    clk,
   input  logic                    rst_n,
   prf_rd_if.mem                   rd,
   input  logic                    wr_en,
   input  logic [`NCPU_PRF_AW-1:0] wr_addr,
   input  logic [`NCPU_DW-1:0]     wr_data
);
   logic [`NCPU_DW-1:0] regs [`NCPU_PRF_N];
   logic [`NCPU_DW-1:0] q_rdata1;
   logic [`NCPU_DW-1:0] q_rdata2;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
      begin
         for (int i = 0; i < `NCPU_PRF_N; i++)
            regs[i] <= '0;
      end
      else if (wr_en)
         regs[wr_addr] <= wr_data;
   end

   // Synchronous reads, new data forwarded on address match
   always_ff @(posedge clk)
   begin
      if (rd.re1)
         q_rdata1 <= (wr_en && wr_addr == rd.raddr1) ? wr_data : regs[rd.raddr1];
      if (rd.re2)
         q_rdata2 <= (wr_en && wr_addr == rd.raddr2) ? wr_data : regs[rd.raddr2];
   end

   assign rd.rdata1 = q_rdata1;   // Holds while re is low
   assign rd.rdata2 = q_rdata2;

endmodule

// File: ro.sv
`include "ncpu_defs.svh"

module ro
(
   input logic   clk,
   input logic   rst_n,
   insn_if.dst   insn,
   prf_rd_if.req rd,
   exop_if.src   exop
);
   import ncpu_pkg::*;

   logic                    ex_valid;
   alu_op_t                 ex_op;
   logic [`NCPU_PRF_AW-1:0] ex_prd;
   logic [`NCPU_DW-1:0]     ex_imm;
   logic                    p_ce;     // Stage load enable
   logic                    src_re;

   // Empty or being drained this cycle
   assign insn.ready = !ex_valid || exop.ready;
   assign p_ce       = insn.valid && insn.ready;

   // Register file acts as the other half of this stage
   assign src_re    = p_ce && (insn.op != ALU_LI);   // LI needs no operands
   assign rd.re1    = src_re;
   assign rd.raddr1 = insn.prs1;
   assign rd.re2    = src_re;
   assign rd.raddr2 = insn.prs2;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         ex_valid <= 1'b0;
      else if (p_ce)
         ex_valid <= 1'b1;
      else if (exop.ready)
         ex_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (p_ce)
      begin
         ex_op  <= insn.op;
         ex_prd <= insn.prd;
         ex_imm <= insn.imm;
      end
   end

   assign exop.valid    = ex_valid;
   assign exop.op       = ex_op;
   assign exop.prd      = ex_prd;
   assign exop.imm      = ex_imm;
   // Read data lines up with the registered control
   assign exop.operand1 = rd.rdata1;
   assign exop.operand2 = rd.rdata2;

endmodule

// File: sim.f
+incdir+.
ncpu_pkg.sv
ncpu_ifs.sv
issue.sv
ro.sv
prf.sv
alu_ex.sv
ncpu_core.sv
ncpu_core_assert.sv
tb_ncpu_core.sv

// File: tb_ncpu_core.sv
`include "ncpu_defs.svh"

module tb_ncpu_core;
   timeunit 1ns;
   timeprecision 100ps;
   import ncpu_pkg::*;

   localparam int N_LI      = `NCPU_PRF_N;
   localparam int N_RAND    = 40;
   localparam int N_CHAIN   = 24;   // 4 chains of 6
   localparam int N_BP      = 48;
   localparam int WD_CYCLES = 5 + 20 * (N_LI + N_RAND + N_CHAIN + N_BP);

   typedef struct packed
   {
      alu_op_t                 op;
      logic [`NCPU_PRF_AW-1:0] prs1;
      logic [`NCPU_PRF_AW-1:0] prs2;
      logic [`NCPU_PRF_AW-1:0] prd;
      logic [`NCPU_DW-1:0]     imm;
   } insn_t;

   logic                    clk = 1'b0;
   logic                    rst_n;
   logic                    in_valid;
   alu_op_t                 in_op;
   logic [`NCPU_PRF_AW-1:0] in_prs1;
   logic [`NCPU_PRF_AW-1:0] in_prs2;
   logic [`NCPU_PRF_AW-1:0] in_prd;
   logic [`NCPU_DW-1:0]     in_imm;
   logic                    in_ready;
   logic                    wb_valid;
   logic [`NCPU_PRF_AW-1:0] wb_prd;
   logic [`NCPU_DW-1:0]     wb_data;
   logic                    wb_ready = 1'b1;

   logic [`NCPU_DW-1:0] model [`NCPU_PRF_N];   // Architectural view, program order
   insn_t               pend_q [$];
   insn_t               wb_insn;
   logic [`NCPU_DW-1:0] wb_exp;
   integer              seed = 32'h626b6a98;
   integer              stall_seed;
   bit                  stall_en = 1'b0;
   int                  sent_cnt = 0;
   int                  done_cnt = 0;
   int                  checks = 0;
   int                  errors = 0;
   int                  tests = 0;
   int                  test_err0 = 0;

   ncpu_core dut_i (.*);

   always #5 clk = ~clk;

   function automatic logic [`NCPU_DW-1:0] ref_result(input alu_op_t op,
      input logic [`NCPU_DW-1:0] a, input logic [`NCPU_DW-1:0] b,
      input logic [`NCPU_DW-1:0] imm);
      case (op)
         ALU_ADD: return a + b;
         ALU_SUB: return a - b;
         ALU_AND: return a & b;
         ALU_OR:  return a | b;
         ALU_XOR: return a ^ b;
         ALU_SLL: return a << b[4:0];
         ALU_SRL: return a >> b[4:0];
         default: return imm;   // LI
      endcase
   endfunction

   // Random wb_ready when enabled
   always @(negedge clk)
   begin
      if (stall_en)
         wb_ready = ($random(stall_seed) % 4) != 0;
      else
         wb_ready = 1'b1;
   end

   always @(posedge clk)
   begin
      if (rst_n && wb_valid && wb_ready)
      begin
         if (pend_q.size() == 0)
         begin
            errors++;
            $display("ERROR at %0t ns: write-back to p%0d with no instruction pending",
                     $time, wb_prd);
         end
         else
         begin
            wb_insn = pend_q.pop_front();
            wb_exp  = ref_result(wb_insn.op, model[wb_insn.prs1], model[wb_insn.prs2],
                                 wb_insn.imm);
            model[wb_insn.prd] = wb_exp;
            checks += 2;
            if (wb_prd !== wb_insn.prd)
            begin
               errors++;
               $display("FAIL %0t ns: wb_prd expected %0d, got %0d", $time, wb_insn.prd, wb_prd);
            end
            if (wb_data !== wb_exp)
            begin
               errors++;
               $display("FAIL %0t ns: wb_data expected %h, got %h", $time, wb_exp, wb_data);
            end
            done_cnt++;
         end
      end
   end

   task automatic issue_insn(input alu_op_t op, input logic [`NCPU_PRF_AW-1:0] s1,
      input logic [`NCPU_PRF_AW-1:0] s2, input logic [`NCPU_PRF_AW-1:0] d,
      input logic [`NCPU_DW-1:0] imm);
      @(negedge clk);
      in_valid = 1'b1;
      in_op    = op;
      in_prs1  = s1;
      in_prs2  = s2;
      in_prd   = d;
      in_imm   = imm;
      @(posedge clk);
      while (!in_ready)
         @(posedge clk);
      pend_q.push_back('{op, s1, s2, d, imm});
      sent_cnt++;
   endtask

   task automatic random_insn(input bit with_li);
      logic [`NCPU_DW-1:0] r;
      alu_op_t             op;
      r = $random(seed);
      op = with_li ? alu_op_t'(r[2:0]) : alu_op_t'(3'(r % 7));
      issue_insn(op, r[7:3], r[12:8], r[17:13], $random(seed));
   endtask

   task automatic dependency_chain(input int len);
      logic [`NCPU_DW-1:0]     r;
      logic [`NCPU_PRF_AW-1:0] prev;
      r    = $random(seed);
      prev = r[4:0];
      for (int k = 0; k < len; k++)
      begin
         r = $random(seed);
         // Odd links read the previous result on both sources
         issue_insn(alu_op_t'(3'(r % 7)), prev, k[0] ? prev : r[7:3], r[12:8], '0);
         prev = r[12:8];
      end
   endtask

   task automatic drain();
      @(negedge clk);
      in_valid = 1'b0;
      while (done_cnt != sent_cnt)
         @(negedge clk);
   endtask

   task automatic report_test(input string name);
      tests++;
      if (errors == test_err0)
         $display("[%0t ns] %s: ok", $time, name);
      else
         $display("[%0t ns] %s: %0d error(s)", $time, name, errors - test_err0);
      test_err0 = errors;
   endtask

   initial
   begin
      stall_seed = seed;
      rst_n      = 1'b0;
      in_valid   = 1'b0;
      in_op      = ALU_ADD;
      in_prs1    = '0;
      in_prs2    = '0;
      in_prd     = '0;
      in_imm     = '0;
      for (int i = 0; i < `NCPU_PRF_N; i++)
         model[i] = '0;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      @(negedge clk);
      checks += 2;
      if (wb_valid !== 1'b0)
      begin
         errors++;
         $display("FAIL %0t ns: wb_valid expected 0, got %b", $time, wb_valid);
      end
      if (in_ready !== 1'b1)
      begin
         errors++;
         $display("FAIL %0t ns: in_ready expected 1, got %b", $time, in_ready);
      end
      report_test("reset state");

      for (int i = 0; i < N_LI; i++)
         issue_insn(ALU_LI, '0, '0, i[`NCPU_PRF_AW-1:0], $random(seed));
      drain();
      report_test("LI seeding");

      for (int i = 0; i < N_RAND; i++)
         random_insn(1'b0);
      drain();
      report_test("random ALU ops");

      for (int c = 0; c < N_CHAIN / 6; c++)
         dependency_chain(6);
      drain();
      report_test("dependency chains");

      @(posedge clk);
      stall_en = 1'b1;
      for (int i = 0; i < N_BP; i++)
         random_insn(1'b1);
      drain();
      @(posedge clk);
      stall_en = 1'b0;
      report_test("back-pressure");

      repeat (10) @(negedge clk);   // Stray write-backs would show up here
      errors += dut_i.assert_i.n_fail;
      $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
      if (errors == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

   initial
   begin
      #(WD_CYCLES * 10);
      $display("Watchdog expired after %0d cycles, %0d results still outstanding",
               WD_CYCLES, sent_cnt - done_cnt);
      $display("Test failed");
      $finish;
   end

endmodule
